// File: list.f
source/icache_pkg.sv
source/icache_way.sv
source/icache_way_select.sv
source/icache_ctrl.sv
source/icache_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/tb_icache.sv

// File: run_sim.sh
#!/bin/sh
# builds the icache testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_icache -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_icache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: source/icache_ctrl.sv
module icache_ctrl
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // cpu fetch port.
    input  addr_t    cpu_req_addr,
    input  logic     cpu_req_valid,
    output logic     cpu_req_ready,
    output word_t    cpu_req_data,
    input  logic     cache_flush,

    // memory port.
    output logic     mem_req_valid,
    output addr_t    mem_req_addr,
    input  logic     mem_req_ready,
    input  word_t    mem_req_data,

    // to the ways.
    output index_t   lookup_index,
    output tag_t     lookup_tag,
    output way_vec_t fill_en,
    output word_t    fill_data,
    output logic     way_flush,

    // from the way selector.
    input  logic     any_hit,
    input  word_t    hit_data,
    input  way_vec_t hit_vec
);

    ctrl_state_t          state_q;
    addr_t                addr_q;
    logic                 refill_q;                 // set while the refilled word is checked.
    logic [WAY_IDX_W-1:0] rr_q [NUM_SETS];          // next victim way for each set.
    logic [WAY_IDX_W-1:0] victim;
    logic [WAY_IDX_W-1:0] hit_idx;
    logic                 refill_done;

    ////////////////////////////////////////////////////////////////////
    // lookup and fill
    ////////////////////////////////////////////////////////////////////

    assign lookup_index = addr_q[OFFSET_W +: INDEX_W];
    assign lookup_tag   = addr_q[ADDR_W-1 -: TAG_W];
    assign fill_data    = mem_req_data;
    assign victim       = rr_q[lookup_index];

    assign refill_done = (state_q == ALLOCATE) && mem_req_valid && mem_req_ready;
    assign fill_en     = refill_done ? (way_vec_t'(1) << victim) : '0;

    // binary index of the way that answered.
    always_comb
    begin
        hit_idx = '0;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (hit_vec[i])
            begin
                hit_idx = WAY_IDX_W'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q       <= IDLE;
            cpu_req_ready <= 1'b0;
            mem_req_valid <= 1'b0;
            way_flush     <= 1'b0;
            refill_q      <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++)
            begin
                rr_q[s] <= '0;
            end
        end
        else
        begin
            cpu_req_ready <= 1'b0;
            way_flush     <= 1'b0;

            case (state_q)
                IDLE:
                begin
                    // flush wins over a request in the same cycle.
                    if (cache_flush)
                    begin
                        way_flush <= 1'b1;
                    end
                    else if (cpu_req_valid && !cpu_req_ready)
                    begin
                        state_q <= COMPARE;
                    end
                end
                COMPARE:
                begin
                    if (any_hit)
                    begin
                        cpu_req_ready <= 1'b1;
                        state_q       <= IDLE;
                        // the hit after a refill is the freshly filled way, so
                        // stepping past it advances the set's round robin.
                        if (refill_q)
                        begin
                            rr_q[lookup_index] <= hit_idx + 1'b1;
                        end
                        refill_q <= 1'b0;
                    end
                    else
                    begin
                        mem_req_valid <= 1'b1;
                        state_q       <= ALLOCATE;
                    end
                end
                ALLOCATE:
                begin
                    if (refill_done)
                    begin
                        mem_req_valid <= 1'b0;
                        refill_q      <= 1'b1;
                        state_q       <= COMPARE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // request address, response word and memory address.
    always_ff @(posedge clk)
    begin
        if (state_q == IDLE && cpu_req_valid && !cpu_req_ready && !cache_flush)
        begin
            addr_q <= cpu_req_addr;
        end
        if (state_q == COMPARE && any_hit)
        begin
            cpu_req_data <= hit_data;
        end
        if (state_q == COMPARE && !any_hit)
        begin
            mem_req_addr <= {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int NUM_WAYS = 2;   // 4 also works with a wider victim pointer.
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 2;   // the byte offset is ignored by the lookup.
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    localparam int NUM_SETS  = 1 << INDEX_W;
    localparam int WAY_IDX_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    ////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;

    // one bit per way, used for hit vectors and fill strobes.
    typedef logic [NUM_WAYS-1:0] way_vec_t;

    ////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////

    // IDLE waits for a request or a flush.
    // COMPARE looks the latched address up in all ways.
    // ALLOCATE holds the memory request until the refill word arrives.
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        COMPARE  = 2'd1,
        ALLOCATE = 2'd2
    } ctrl_state_t;

endpackage

// File: source/icache_top.sv
module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  addr_t cpu_req_addr,
    input  logic  cpu_req_valid,
    output logic  cpu_req_ready,
    output word_t cpu_req_data,
    input  logic  cache_flush,

    output logic  mem_req_valid,
    output addr_t mem_req_addr,
    input  logic  mem_req_ready,
    input  word_t mem_req_data
);

    index_t   lookup_index;
    tag_t     lookup_tag;
    way_vec_t fill_en;
    word_t    fill_data;
    logic     way_flush;

    way_vec_t way_hit;
    word_t    way_data [NUM_WAYS];

    logic     any_hit;
    word_t    hit_data;
    way_vec_t hit_vec;

    icache_ctrl i_icache_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .cache_flush   (cache_flush),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .fill_en       (fill_en),
        .fill_data     (fill_data),
        .way_flush     (way_flush),
        .any_hit       (any_hit),
        .hit_data      (hit_data),
        .hit_vec       (hit_vec)
    );

    // every way sees the same index and tag; only its fill strobe differs.
    for (genvar g = 0; g < NUM_WAYS; g++)
    begin : g_way
        icache_way i_icache_way (
            .clk          (clk),
            .rst          (rst),
            .flush        (way_flush),
            .lookup_index (lookup_index),
            .lookup_tag   (lookup_tag),
            .fill_en      (fill_en[g]),
            .fill_data    (fill_data),
            .hit          (way_hit[g]),
            .data         (way_data[g])
        );
    end

    icache_way_select i_icache_way_select (
        .way_hit  (way_hit),
        .way_data (way_data),
        .any_hit  (any_hit),
        .hit_data (hit_data),
        .hit_vec  (hit_vec)
    );

endmodule

// File: source/icache_way.sv
module icache_way
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,

    input  index_t lookup_index,
    input  tag_t   lookup_tag,

    input  logic   fill_en,
    input  word_t  fill_data,

    output logic   hit,
    output word_t  data
);

    ////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////

    logic [NUM_SETS-1:0] valid_q;
    tag_t                tag_q  [NUM_SETS];
    word_t               data_q [NUM_SETS];

    // reset or flush invalidates every entry.
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid_q <= '0;
        end
        else if (fill_en)
        begin
            valid_q[lookup_index] <= 1'b1;
        end
    end

    // tag and word are written together with the valid bit.
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_q[lookup_index]  <= lookup_tag;
            data_q[lookup_index] <= fill_data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////

    // reads are asynchronous from the register arrays.
    always_comb
    begin
        hit  = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
        data = data_q[lookup_index];
    end

endmodule

// File: source/icache_way_select.sv
module icache_way_select
    import icache_pkg::*;
(
    input  way_vec_t way_hit,
    input  word_t    way_data [NUM_WAYS],

    output logic     any_hit,
    output word_t    hit_data,
    output way_vec_t hit_vec
);

    // a line can live in only one way, so more than one hit bit
    // should never be seen. the lowest way still wins if it happens.
    always_comb
    begin
        logic found;

        found    = 1'b0;
        hit_vec  = '0;
        hit_data = '0;

        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (way_hit[i] && !found)
            begin
                found      = 1'b1;
                hit_vec[i] = 1'b1;
                hit_data   = way_data[i];
            end
        end

        any_hit = found;
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;    // 8 ns clock.
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset drops just after the last reset edge, like any other input.
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: verification/tb_icache.sv
module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t MEM_XOR     = 32'h5a3c_96e1;
    localparam int    REQ_TIMEOUT = 300;
    localparam int    RST_TIMEOUT = 50;
    localparam addr_t ASSOC_SEQ [7] = '{32'h2024, 32'h3024, 32'h2024, 32'h4024,
                                        32'h3024, 32'h2026, 32'h4024};

    logic  clk;
    logic  rst;
    addr_t cpu_req_addr;
    logic  cpu_req_valid;
    logic  cpu_req_ready;
    word_t cpu_req_data;
    logic  cache_flush;
    logic  mem_req_valid;
    addr_t mem_req_addr;
    logic  mem_req_ready;
    word_t mem_req_data;
    int    min_delay;
    int    max_delay;
    int    refill_count;

    logic  ref_valid [NUM_WAYS][NUM_SETS];      // reference cache state.
    tag_t  ref_tag   [NUM_WAYS][NUM_SETS];
    int    ref_rr    [NUM_SETS];
    int    ref_refills;
    word_t exp_word_q   [$];                    // expected responses in request order.
    int    exp_refill_q [$];

    string  test_name = "reset";
    integer seed;
    int     checks;
    int     errors;
    int     test_errors;
    int     chk_idx = 0;
    int     chk_checks = 0;
    int     chk_errors = 0;
    logic   mem_wait_q = 1'b0;
    logic   timed_out = 1'b0;

    tb_clock_gen i_clock_gen (.clk(clk), .rst(rst));

    icache_top i_icache_top (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .cache_flush   (cache_flush),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    tb_mem_model #(.DATA_XOR(MEM_XOR)) i_mem_model (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .min_delay     (min_delay),
        .max_delay     (max_delay),
        .refill_count  (refill_count)
    );

    ////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////

    function automatic word_t mem_word(input addr_t addr);
        return word_t'(addr >> OFFSET_W) ^ MEM_XOR;
    endfunction

    // the address of the whole word that holds a byte.
    function automatic addr_t word_aligned(input addr_t addr);
        return addr & ~addr_t'((1 << OFFSET_W) - 1);
    endfunction

    // updates the model and returns 1 when the request needs a refill.
    function automatic bit ref_access(input addr_t addr);
        index_t idx;
        tag_t   tag;
        int     victim;

        idx = addr[OFFSET_W +: INDEX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag)
                return 1'b0;
        end
        victim                 = ref_rr[idx];
        ref_valid[victim][idx] = 1'b1;
        ref_tag[victim][idx]   = tag;
        ref_rr[idx]            = (victim + 1) % NUM_WAYS;   // round robin per set.
        return 1'b1;
    endfunction

    task automatic clear_ref_valid();
        foreach (ref_valid[w, s])
            ref_valid[w][s] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return errors + chk_errors;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = total_errors();
    endtask

    task automatic end_test();
        $display("test %-10s done, %0d errors", test_name, total_errors() - test_errors);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in test %s: %s", test_name, what);
        timed_out = 1'b1;
        errors++;
    endtask

    // one request; latency counts cycles from valid to the ready pulse.
    task automatic fetch(input addr_t addr, output int latency);
        latency = 0;
        if (!timed_out)
        begin
            if (ref_access(addr))
                ref_refills++;
            exp_word_q.push_back(mem_word(addr));
            exp_refill_q.push_back(ref_refills);
            cpu_req_addr  = addr;
            cpu_req_valid = 1'b1;
            @(negedge clk);
            while (!cpu_req_ready && latency < REQ_TIMEOUT)
            begin
                latency++;
                @(negedge clk);
            end
            if (!cpu_req_ready)
            begin
                report_timeout($sformatf("no cpu_req_ready for address %h", addr));
            end
            else
            begin
                @(posedge clk);
                #1;
                cpu_req_valid = 1'b0;
            end
        end
    endtask

    task automatic flush_cache();
        cache_flush = 1'b1;
        @(posedge clk);
        #1;
        cache_flush = 1'b0;
        clear_ref_valid();
    endtask

    ////////////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (rst === 1'b0 && cpu_req_ready && chk_idx >= exp_word_q.size())
        begin
            $display("unexpected cpu_req_ready with no request outstanding in test %s",
                     test_name);
            chk_errors++;
        end
        else if (rst === 1'b0 && cpu_req_ready)
        begin
            chk_checks += 2;
            assert (cpu_req_data == exp_word_q[chk_idx])
            else
            begin
                $display("CHECK FAILED %s data at %h expected %h actual %h", test_name,
                         cpu_req_addr, exp_word_q[chk_idx], cpu_req_data);
                chk_errors++;
            end
            assert (refill_count == exp_refill_q[chk_idx])
            else
            begin
                $display("CHECK FAILED %s refills expected %0d actual %0d", test_name,
                         exp_refill_q[chk_idx], refill_count);
                chk_errors++;
            end
            chk_idx++;
        end
        // a waiting memory request keeps valid and its word-aligned address.
        if (rst === 1'b0 && mem_wait_q)
        begin
            chk_checks++;
            assert (mem_req_valid)
            else
            begin
                $display("mem_req_valid dropped before mem_req_ready in test %s", test_name);
                chk_errors++;
            end
        end
        if (rst === 1'b0 && mem_req_valid)
        begin
            chk_checks++;
            assert (mem_req_addr == word_aligned(cpu_req_addr))
            else
            begin
                $display("CHECK FAILED %s mem_req_addr expected %h actual %h", test_name,
                         word_aligned(cpu_req_addr), mem_req_addr);
                chk_errors++;
            end
        end
        mem_wait_q = mem_req_valid && !mem_req_ready;
    end

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial
    begin
        int          lat;
        int          waited;
        logic [31:0] r;

        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        cache_flush   = 1'b0;
        min_delay     = 0;
        max_delay     = 5;
        seed          = 84;
        checks        = 0;
        errors        = 0;
        ref_refills   = 0;
        waited        = 0;
        clear_ref_valid();
        foreach (ref_rr[s])
            ref_rr[s] = 0;
        while (rst !== 1'b0 && waited < RST_TIMEOUT)
        begin
            waited++;
            @(posedge clk);
        end
        if (rst !== 1'b0)
        begin
            report_timeout("reset was never released");
        end
        else
        begin
            #1;
            start_test("cold_miss");
            for (int i = 0; i < 8; i++)
                fetch(32'h0000_1000 + i * 4, lat);
            end_test();

            start_test("hit");
            for (int i = 0; i < 8; i++)
            begin
                fetch(32'h0000_1000 + i * 4, lat);
                checks++;
                assert (lat == 2)
                else
                begin
                    $display("CHECK FAILED %s latency expected 2 actual %0d", test_name, lat);
                    errors++;
                end
            end
            end_test();

            start_test("assoc");                     // three tags share set 9.
            foreach (ASSOC_SEQ[i])
                fetch(ASSOC_SEQ[i], lat);
            end_test();

            start_test("flush");
            flush_cache();
            fetch(32'h0000_1000, lat);
            end_test();

            start_test("backpress");
            min_delay = 10;
            max_delay = 20;
            for (int i = 0; i < 4; i++)
                fetch(32'h0000_5028 + i * 4, lat);
            min_delay = 0;
            max_delay = 5;
            end_test();

            start_test("random");                    // four tags over sets 0 to 3.
            for (int i = 0; i < 200; i++)
            begin
                r = $random(seed);
                fetch({24'h000100, r[1:0], 2'b00, r[3:2], r[5:4]}, lat);
            end
            end_test();
        end

        $display("checks %0d, errors %0d", checks + chk_checks, total_errors());
        if (total_errors() == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verification/tb_mem_model.sv
module tb_mem_model
    import icache_pkg::*;
#(
    parameter word_t DATA_XOR = '0
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_req_valid,
    input  addr_t mem_req_addr,
    output logic  mem_req_ready,
    output word_t mem_req_data,
    input  int    min_delay,
    input  int    max_delay,
    output int    refill_count
);

    timeunit 1ns;
    timeprecision 100ps;

    integer seed;
    int     delay;

    ////////////////////////////////////////////////////////////////////
    // refill responder
    ////////////////////////////////////////////////////////////////////

    // one refill at a time; ready is raised for a single cycle.
    initial
    begin
        seed          = 84;
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        refill_count  = 0;
        forever
        begin
            @(negedge clk);
            if (rst === 1'b0 && mem_req_valid)
            begin
                delay = min_delay + int'($unsigned($random(seed)) % (max_delay - min_delay + 1));
                repeat (delay + 1) @(posedge clk);
                #1;
                mem_req_ready = 1'b1;
                mem_req_data  = word_t'(mem_req_addr >> OFFSET_W) ^ DATA_XOR;
                refill_count  = refill_count + 1;
                @(posedge clk);
                #1;
                mem_req_ready = 1'b0;                   // the cache took the word at that edge.
            end
        end
    end

endmodule
